// ==== Bender.yml ====
package:
  name: pipe16

sources:
  - files:
      - design/pipe16_pkg.sv
      - design/pipe16_predictor.sv
      - design/pipe16_fetch.sv
      - design/pipe16_regfile.sv
      - design/pipe16_decode.sv
      - design/pipe16_execute.sv
      - design/pipe16_writeback.sv
      - design/pipe16_core.sv
  - target: test
    files:
      - verif/pipe16_tb_mem.sv
      - verif/pipe16_tb.sv

// ==== design/pipe16_core.sv ====
`timescale 1ns/10ps

module pipe16_core (
	input logic clk,
	input logic rst,
	output pipe16_pkg::word_t imem_addr,
	input pipe16_pkg::word_t imem_data,
	output pipe16_pkg::word_t dmem_raddr,
	input pipe16_pkg::word_t dmem_rdata,
	output logic dmem_wen,
	output pipe16_pkg::word_t dmem_waddr,
	output pipe16_pkg::word_t dmem_wdata,
	output logic halt
);

	pipe16_pkg::word_t pc_lookup;
	pipe16_pkg::word_t predicted_pc;

	pipe16_pkg::word_t if_instr;
	pipe16_pkg::word_t if_pc;
	pipe16_pkg::word_t if_pred_pc;
	logic if_valid;

	pipe16_pkg::reg_addr_t raddr0;
	pipe16_pkg::reg_addr_t raddr1;
	pipe16_pkg::word_t rdata0;
	pipe16_pkg::word_t rdata1;

	logic stall;
	pipe16_pkg::decoded_t id_dec;
	pipe16_pkg::word_t id_va;
	pipe16_pkg::word_t id_vb;
	pipe16_pkg::word_t id_pc;
	pipe16_pkg::word_t id_pred_pc;
	logic id_valid;

	logic redirect;
	pipe16_pkg::word_t redirect_pc;
	logic pred_update;
	pipe16_pkg::decoded_t ex_dec;
	pipe16_pkg::word_t ex_result;
	logic ex_valid;

	logic wb_wen;
	pipe16_pkg::reg_addr_t wb_addr;
	pipe16_pkg::word_t wb_data;
	logic freeze;

	// A jump being resolved in execute has its own pc in the decode output register
	pipe16_predictor u_predictor (
		.clk(clk), .rst(rst),
		.lookup_pc(pc_lookup), .predicted_pc(predicted_pc),
		.update_en(pred_update), .update_pc(id_pc), .update_target(redirect_pc)
	);

	pipe16_fetch u_fetch (
		.clk(clk), .rst(rst),
		.stall(stall), .freeze(freeze), .redirect(redirect), .redirect_pc(redirect_pc),
		.predicted_pc(predicted_pc), .imem_addr(imem_addr), .imem_data(imem_data),
		.pc_lookup(pc_lookup), .if_instr(if_instr), .if_pc(if_pc),
		.if_pred_pc(if_pred_pc), .if_valid(if_valid)
	);

	pipe16_regfile u_regfile (
		.clk(clk), .rst(rst),
		.raddr0(raddr0), .raddr1(raddr1), .rdata0(rdata0), .rdata1(rdata1),
		.wen(wb_wen), .waddr(wb_addr), .wdata(wb_data)
	);

	pipe16_decode u_decode (
		.clk(clk), .rst(rst),
		.freeze(freeze), .redirect(redirect),
		.if_instr(if_instr), .if_pc(if_pc), .if_pred_pc(if_pred_pc), .if_valid(if_valid),
		.raddr0(raddr0), .raddr1(raddr1), .rdata0(rdata0), .rdata1(rdata1),
		.stall(stall), .id_dec(id_dec), .id_va(id_va), .id_vb(id_vb),
		.id_pc(id_pc), .id_pred_pc(id_pred_pc), .id_valid(id_valid)
	);

	pipe16_execute u_execute (
		.clk(clk), .rst(rst), .freeze(freeze),
		.id_dec(id_dec), .id_va(id_va), .id_vb(id_vb), .id_pc(id_pc),
		.id_pred_pc(id_pred_pc), .id_valid(id_valid),
		.wb_wen(wb_wen), .wb_addr(wb_addr), .wb_data(wb_data),
		.redirect(redirect), .redirect_pc(redirect_pc), .pred_update(pred_update),
		.dmem_raddr(dmem_raddr), .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata),
		.dmem_wen(dmem_wen), .ex_dec(ex_dec), .ex_result(ex_result), .ex_valid(ex_valid)
	);

	pipe16_writeback u_writeback (
		.clk(clk), .rst(rst),
		.ex_dec(ex_dec), .ex_result(ex_result), .ex_valid(ex_valid),
		.dmem_rdata(dmem_rdata),
		.wb_wen(wb_wen), .wb_addr(wb_addr), .wb_data(wb_data),
		.freeze(freeze), .halt(halt)
	);

endmodule

// ==== design/pipe16_decode.sv ====
`timescale 1ns/10ps

module pipe16_decode (
	input logic clk,
	input logic rst,
	input logic freeze,
	input logic redirect,
	input pipe16_pkg::word_t if_instr,
	input pipe16_pkg::word_t if_pc,
	input pipe16_pkg::word_t if_pred_pc,
	input logic if_valid,
	output pipe16_pkg::reg_addr_t raddr0,
	output pipe16_pkg::reg_addr_t raddr1,
	input pipe16_pkg::word_t rdata0,
	input pipe16_pkg::word_t rdata1,
	output logic stall,
	output pipe16_pkg::decoded_t id_dec,
	output pipe16_pkg::word_t id_va,
	output pipe16_pkg::word_t id_vb,
	output pipe16_pkg::word_t id_pc,
	output pipe16_pkg::word_t id_pred_pc,
	output logic id_valid
);

	logic [3:0] opcode;
	logic [3:0] xop;
	pipe16_pkg::decoded_t dec;
	pipe16_pkg::decoded_t bubble;
	logic reads_a;
	logic reads_b;
	logic load_hazard;
	logic insert_bubble;

	assign opcode = if_instr[15:12];
	assign xop = if_instr[7:4];

	always_comb begin
		dec = '0;
		dec.ra = if_instr[11:8];
		dec.rb = if_instr[7:4];
		dec.rt = if_instr[3:0];
		dec.imm = if_instr[11:4];
		dec.cond = xop[1:0];
		case (opcode)
			pipe16_pkg::op_sub: dec.op = pipe16_pkg::alu_sub;
			pipe16_pkg::op_add: dec.op = pipe16_pkg::alu_add;
			pipe16_pkg::op_inc: dec.op = pipe16_pkg::alu_inc;
			pipe16_pkg::op_dec: dec.op = pipe16_pkg::alu_dec;
			pipe16_pkg::op_cmp: dec.op = pipe16_pkg::alu_cmp;
			pipe16_pkg::op_movl: dec.op = pipe16_pkg::alu_movl;
			pipe16_pkg::op_movh: dec.op = pipe16_pkg::alu_movh;
			pipe16_pkg::op_jump: begin
				if (xop inside {pipe16_pkg::xop_jz, pipe16_pkg::xop_jnz,
						pipe16_pkg::xop_js, pipe16_pkg::xop_jns}) begin
					dec.op = pipe16_pkg::alu_jump;
					dec.is_jump = 1'b1;
				end else begin
					dec.op = pipe16_pkg::op_illegal;
				end
			end
			pipe16_pkg::op_mem: begin
				if (xop == pipe16_pkg::xop_ld) begin
					dec.op = pipe16_pkg::alu_ld;
					dec.is_load = 1'b1;
				end else if (xop == pipe16_pkg::xop_st) begin
					dec.op = pipe16_pkg::alu_st;
					dec.is_store = 1'b1;
				end else begin
					dec.op = pipe16_pkg::op_illegal;
				end
			end
			default: dec.op = pipe16_pkg::op_illegal;
		endcase
		dec.writes_reg = dec.op inside {pipe16_pkg::alu_sub, pipe16_pkg::alu_add,
			pipe16_pkg::alu_inc, pipe16_pkg::alu_dec, pipe16_pkg::alu_cmp,
			pipe16_pkg::alu_movl, pipe16_pkg::alu_movh, pipe16_pkg::alu_ld};
	end

	always_comb begin
		bubble = '0;
		bubble.op = pipe16_pkg::op_none;
	end

	// Only the three-register forms read rb, everything else reads rt on port 1
	assign raddr0 = dec.ra;
	assign raddr1 = (dec.op inside {pipe16_pkg::alu_sub, pipe16_pkg::alu_add,
		pipe16_pkg::alu_cmp}) ? dec.rb : dec.rt;

	assign reads_a = dec.op inside {pipe16_pkg::alu_sub, pipe16_pkg::alu_add,
		pipe16_pkg::alu_cmp, pipe16_pkg::alu_jump, pipe16_pkg::alu_ld, pipe16_pkg::alu_st};
	assign reads_b = !(dec.op inside {pipe16_pkg::alu_movl, pipe16_pkg::alu_ld,
		pipe16_pkg::op_illegal});

	// Load data only shows up in writeback, one cycle too late for the next instruction
	assign load_hazard = id_valid && id_dec.is_load && id_dec.rt != '0 &&
		((reads_a && id_dec.rt == raddr0) || (reads_b && id_dec.rt == raddr1));
	assign stall = if_valid && load_hazard && !redirect;

	assign insert_bubble = !if_valid || stall || redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
		end else if (!freeze) begin
			id_valid <= !insert_bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			id_dec <= insert_bubble ? bubble : dec;
			id_va <= rdata0;
			id_vb <= rdata1;
			id_pc <= if_pc;
			id_pred_pc <= if_pred_pc;
		end
	end

endmodule

// ==== design/pipe16_execute.sv ====
`timescale 1ns/10ps

module pipe16_execute (
	input logic clk,
	input logic rst,
	input logic freeze,
	input pipe16_pkg::decoded_t id_dec,
	input pipe16_pkg::word_t id_va,
	input pipe16_pkg::word_t id_vb,
	input pipe16_pkg::word_t id_pc,
	input pipe16_pkg::word_t id_pred_pc,
	input logic id_valid,
	input logic wb_wen,
	input pipe16_pkg::reg_addr_t wb_addr,
	input pipe16_pkg::word_t wb_data,
	output logic redirect,
	output pipe16_pkg::word_t redirect_pc,
	output logic pred_update,
	output pipe16_pkg::word_t dmem_raddr,
	output pipe16_pkg::word_t dmem_waddr,
	output pipe16_pkg::word_t dmem_wdata,
	output logic dmem_wen,
	output pipe16_pkg::decoded_t ex_dec,
	output pipe16_pkg::word_t ex_result,
	output logic ex_valid
);

	pipe16_pkg::reg_addr_t b_addr;
	pipe16_pkg::word_t va;
	pipe16_pkg::word_t vb;
	pipe16_pkg::word_t result;
	pipe16_pkg::word_t next_pc;
	logic taken;

	// The writeback bus carries last cycle's execute result, or the load data
	assign b_addr = (id_dec.op inside {pipe16_pkg::alu_sub, pipe16_pkg::alu_add,
		pipe16_pkg::alu_cmp}) ? id_dec.rb : id_dec.rt;
	assign va = (wb_wen && wb_addr == id_dec.ra) ? wb_data : id_va;
	// Holds vb for the three-register forms and vt for all others
	assign vb = (wb_wen && wb_addr == b_addr) ? wb_data : id_vb;

	always_comb begin
		case (id_dec.op)
			pipe16_pkg::alu_sub: result = va - vb;
			pipe16_pkg::alu_add: result = va + vb;
			pipe16_pkg::alu_inc: result = vb + {8'h00, id_dec.imm};
			pipe16_pkg::alu_dec: result = vb - {8'h00, id_dec.imm};
			pipe16_pkg::alu_cmp: result = {15'd0, va == vb};
			pipe16_pkg::alu_movl: result = {{8{id_dec.imm[7]}}, id_dec.imm};
			pipe16_pkg::alu_movh: result = {id_dec.imm, vb[7:0]};
			default: result = '0;
		endcase
	end

	always_comb begin
		case ({2'b00, id_dec.cond})
			pipe16_pkg::xop_jz: taken = (va == '0);
			pipe16_pkg::xop_jnz: taken = (va != '0);
			pipe16_pkg::xop_js: taken = va[15];
			pipe16_pkg::xop_jns: taken = !va[15];
			default: taken = 1'b0;
		endcase
	end

	// Every valid instruction checks the guess, so aliased predictor hits are also caught
	assign next_pc = (id_dec.is_jump && taken) ? vb : id_pc + 16'd2;
	assign redirect = id_valid && !freeze && next_pc != id_pred_pc;
	assign redirect_pc = next_pc;
	assign pred_update = redirect && id_dec.is_jump && taken;

	assign dmem_raddr = va;
	assign dmem_waddr = va;
	assign dmem_wdata = vb;
	assign dmem_wen = id_valid && id_dec.is_store && !freeze;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (!freeze) begin
			ex_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			ex_dec <= id_dec;
			ex_result <= result;
		end
	end

endmodule

// ==== design/pipe16_fetch.sv ====
`timescale 1ns/10ps

module pipe16_fetch (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic freeze,
	input logic redirect,
	input pipe16_pkg::word_t redirect_pc,
	input pipe16_pkg::word_t predicted_pc,
	output pipe16_pkg::word_t imem_addr,
	input pipe16_pkg::word_t imem_data,
	output pipe16_pkg::word_t pc_lookup,
	output pipe16_pkg::word_t if_instr,
	output pipe16_pkg::word_t if_pc,
	output pipe16_pkg::word_t if_pred_pc,
	output logic if_valid
);

	pipe16_pkg::word_t pc;
	pipe16_pkg::word_t hold_instr;
	logic hold_valid;

	assign imem_addr = pc;
	assign pc_lookup = pc;

	// After a stall the memory already returns the word after the held one,
	// so decode is fed from the hold buffer for one cycle
	assign if_instr = hold_valid ? hold_instr : imem_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			if_valid <= 1'b0;
			hold_valid <= 1'b0;
		end else if (!freeze) begin
			if (redirect) begin
				pc <= redirect_pc;
				if_valid <= 1'b0;
				hold_valid <= 1'b0;
			end else if (stall) begin
				hold_valid <= 1'b1;
			end else begin
				pc <= predicted_pc;
				if_valid <= 1'b1;
				hold_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			if (stall) begin
				hold_instr <= if_instr;
			end else begin
				if_pc <= pc;
				if_pred_pc <= predicted_pc;
			end
		end
	end

endmodule

// ==== design/pipe16_pkg.sv ====
package pipe16_pkg;

	localparam int word_w = 16;
	localparam int reg_addr_w = 4;
	localparam int imm_w = 8;
	localparam int opcode_w = 4;

	// The predictor is indexed by pc bits 10 to 1, since instructions are two bytes apart
	localparam int pred_index_w = 10;
	localparam int pred_entries = 1 << pred_index_w;

	localparam logic [opcode_w-1:0] op_sub = 4'd0;
	localparam logic [opcode_w-1:0] op_add = 4'd1;
	localparam logic [opcode_w-1:0] op_inc = 4'd2;
	localparam logic [opcode_w-1:0] op_dec = 4'd3;
	localparam logic [opcode_w-1:0] op_cmp = 4'd5;
	localparam logic [opcode_w-1:0] op_movl = 4'd8;
	localparam logic [opcode_w-1:0] op_movh = 4'd9;
	localparam logic [opcode_w-1:0] op_jump = 4'd14;
	localparam logic [opcode_w-1:0] op_mem = 4'd15;

	// Secondary opcode in bits 7 to 4 of jump instructions
	localparam logic [opcode_w-1:0] xop_jz = 4'd0;
	localparam logic [opcode_w-1:0] xop_jnz = 4'd1;
	localparam logic [opcode_w-1:0] xop_js = 4'd2;
	localparam logic [opcode_w-1:0] xop_jns = 4'd3;

	// Secondary opcode of memory instructions
	localparam logic [opcode_w-1:0] xop_ld = 4'd0;
	localparam logic [opcode_w-1:0] xop_st = 4'd1;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		alu_sub,
		alu_add,
		alu_inc,
		alu_dec,
		alu_cmp,
		alu_movl,
		alu_movh,
		alu_ld,
		alu_st,
		alu_jump,
		op_none,
		op_illegal
	} alu_op_t;

	// Everything execute and writeback need to know about one instruction
	typedef struct packed {
		alu_op_t op;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		logic [imm_w-1:0] imm;
		logic writes_reg;
		logic is_load;
		logic is_store;
		logic is_jump;
		logic [1:0] cond;
	} decoded_t;

endpackage

// ==== design/pipe16_predictor.sv ====
`timescale 1ns/10ps

module pipe16_predictor (
	input logic clk,
	input logic rst,
	input pipe16_pkg::word_t lookup_pc,
	output pipe16_pkg::word_t predicted_pc,
	input logic update_en,
	input pipe16_pkg::word_t update_pc,
	input pipe16_pkg::word_t update_target
);

	pipe16_pkg::word_t targets [pipe16_pkg::pred_entries];
	logic [pipe16_pkg::pred_entries-1:0] entry_valid;

	logic [pipe16_pkg::pred_index_w-1:0] lookup_idx;
	logic [pipe16_pkg::pred_index_w-1:0] update_idx;

	assign lookup_idx = lookup_pc[pipe16_pkg::pred_index_w:1];
	assign update_idx = update_pc[pipe16_pkg::pred_index_w:1];

	// Without a trained entry the guess is simply the next sequential word
	assign predicted_pc = entry_valid[lookup_idx] ? targets[lookup_idx] : lookup_pc + 16'd2;

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_valid <= '0;
		end else if (update_en) begin
			entry_valid[update_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (update_en) begin
			targets[update_idx] <= update_target;
		end
	end

endmodule

// ==== design/pipe16_regfile.sv ====
`timescale 1ns/10ps

module pipe16_regfile (
	input logic clk,
	input logic rst,
	input pipe16_pkg::reg_addr_t raddr0,
	input pipe16_pkg::reg_addr_t raddr1,
	output pipe16_pkg::word_t rdata0,
	output pipe16_pkg::word_t rdata1,
	input logic wen,
	input pipe16_pkg::reg_addr_t waddr,
	input pipe16_pkg::word_t wdata
);

	pipe16_pkg::word_t regs [16];

	// A write in the same cycle is visible to the reader right away
	assign rdata0 = (raddr0 == '0) ? '0 : (wen && waddr == raddr0) ? wdata : regs[raddr0];
	assign rdata1 = (raddr1 == '0) ? '0 : (wen && waddr == raddr1) ? wdata : regs[raddr1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

// ==== design/pipe16_writeback.sv ====
`timescale 1ns/10ps

module pipe16_writeback (
	input logic clk,
	input logic rst,
	input pipe16_pkg::decoded_t ex_dec,
	input pipe16_pkg::word_t ex_result,
	input logic ex_valid,
	input pipe16_pkg::word_t dmem_rdata,
	output logic wb_wen,
	output pipe16_pkg::reg_addr_t wb_addr,
	output pipe16_pkg::word_t wb_data,
	output logic freeze,
	output logic halt
);

	logic halting;

	// The data memory answers a load in the cycle after execute addressed it
	assign wb_data = ex_dec.is_load ? dmem_rdata : ex_result;
	assign wb_addr = ex_dec.rt;
	assign wb_wen = ex_valid && ex_dec.writes_reg && ex_dec.rt != '0;

	assign halting = ex_valid && ex_dec.op == pipe16_pkg::op_illegal;

	// Freezing already in the halting cycle keeps a younger store in execute
	// from reaching memory
	assign freeze = halt || halting;

	always_ff @(posedge clk) begin
		if (rst) begin
			halt <= 1'b0;
		end else if (halting) begin
			halt <= 1'b1;
		end
	end

endmodule

// ==== pipe16.f ====
design/pipe16_pkg.sv
design/pipe16_predictor.sv
design/pipe16_fetch.sv
design/pipe16_regfile.sv
design/pipe16_decode.sv
design/pipe16_execute.sv
design/pipe16_writeback.sv
design/pipe16_core.sv
verif/pipe16_tb_mem.sv
verif/pipe16_tb.sv

// ==== verif/pipe16_tb.sv ====
`timescale 1ns/10ps

module pipe16_tb;

	localparam int max_tests = 24;
	localparam int run_limit = 120;
	// Opcode 4 is unassigned, so this word stops the core in writeback
	localparam pipe16_pkg::word_t illegal_word = 16'h4000;

	logic clk;
	logic rst;
	pipe16_pkg::word_t imem_addr;
	pipe16_pkg::word_t imem_data;
	pipe16_pkg::word_t dmem_raddr;
	pipe16_pkg::word_t dmem_rdata;
	logic dmem_wen;
	pipe16_pkg::word_t dmem_waddr;
	pipe16_pkg::word_t dmem_wdata;
	logic halt;

	logic load_en;
	logic [4:0] load_addr;
	pipe16_pkg::word_t load_instr;
	pipe16_pkg::word_t load_data;
	logic [4:0] peek_addr;
	pipe16_pkg::word_t peek_data;

	string names [max_tests];
	pipe16_pkg::word_t progs [max_tests][16];
	logic [4:0] init_addr [max_tests];
	pipe16_pkg::word_t init_data [max_tests];
	logic [4:0] check_addr [max_tests];
	pipe16_pkg::word_t expected [max_tests];
	int num_tests;
	int error_count;
	int pass_count;

	pipe16_core u_pipe16_core (
		.clk(clk), .rst(rst),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_raddr(dmem_raddr), .dmem_rdata(dmem_rdata),
		.dmem_wen(dmem_wen), .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata),
		.halt(halt)
	);

	pipe16_tb_mem u_tb_mem (
		.clk(clk),
		.imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_raddr(dmem_raddr), .dmem_rdata(dmem_rdata),
		.dmem_wen(dmem_wen), .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata),
		.load_en(load_en), .load_addr(load_addr), .load_instr(load_instr),
		.load_data(load_data), .peek_addr(peek_addr), .peek_data(peek_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Register form, also used for jumps and memory ops with the xop in the rb field
	function automatic pipe16_pkg::word_t reg_form(input logic [3:0] op,
		input pipe16_pkg::reg_addr_t ra, input logic [3:0] rb, input pipe16_pkg::reg_addr_t rt);
		return {op, ra, rb, rt};
	endfunction

	function automatic pipe16_pkg::word_t imm_form(input logic [3:0] op, input logic [7:0] imm,
		input pipe16_pkg::reg_addr_t rt);
		return {op, imm, rt};
	endfunction

	// Program words are packed first word at the top of the vector
	task automatic table_entry(input string name, input logic [4:0] ia,
		input pipe16_pkg::word_t id, input logic [4:0] ca, input pipe16_pkg::word_t exp,
		input int count, input logic [255:0] words);
		names[num_tests] = name;
		init_addr[num_tests] = ia;
		init_data[num_tests] = id;
		check_addr[num_tests] = ca;
		expected[num_tests] = exp;
		for (int i = 0; i < 16; i++) begin
			if (i < count) begin
				progs[num_tests][i] = words[(count - 1 - i) * 16 +: 16];
			end else begin
				progs[num_tests][i] = {4'h4, 8'h00, i[3:0]};
			end
		end
		num_tests++;
	endtask

	// A taken jump skips the overwrite of r5, so the stored word tells the two paths apart
	task automatic branch_case(input string name, input logic [3:0] xop, input logic [7:0] cond,
		input logic taken, input logic [4:0] addr);
		table_entry(name, 5'd31, 16'h0000, addr, taken ? 16'h0022 : 16'h0011, 8, {
			imm_form(pipe16_pkg::op_movl, 8'h22, 4'd5), imm_form(pipe16_pkg::op_movl, cond, 4'd1),
			imm_form(pipe16_pkg::op_movl, 8'h0a, 4'd2), reg_form(pipe16_pkg::op_jump, 4'd1, xop, 4'd2),
			imm_form(pipe16_pkg::op_movl, 8'h11, 4'd5),
			imm_form(pipe16_pkg::op_movl, {3'b000, addr}, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd5), illegal_word});
	endtask

	task automatic fill_memories(input int n);
		int r;
		for (int i = 0; i < 32; i++) begin
			r = $urandom;
			load_en = 1'b1;
			load_addr = i[4:0];
			load_instr = progs[n][i[3:0]];
			load_data = (i[4:0] == init_addr[n]) ? init_data[n] : r[15:0];
			@(posedge clk);
			#1;
		end
		load_en = 1'b0;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic compare_word(input string name, input pipe16_pkg::word_t exp,
		input pipe16_pkg::word_t act);
		if (act !== exp) begin
			error_count++;
			$display("FAILED %0s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			error_count++;
			$display("FAILED %0s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic build_table();
		table_entry("movl_movh", 5'd31, 16'h0000, 5'd5, 16'h1234, 4, {
			imm_form(pipe16_pkg::op_movl, 8'h34, 4'd1), imm_form(pipe16_pkg::op_movh, 8'h12, 4'd1),
			imm_form(pipe16_pkg::op_movl, 8'h05, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd2, pipe16_pkg::xop_st, 4'd1)});
		table_entry("movl_sign", 5'd31, 16'h0000, 5'd6, 16'hfff0, 3, {
			imm_form(pipe16_pkg::op_movl, 8'hf0, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h06, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd2, pipe16_pkg::xop_st, 4'd1)});
		table_entry("add", 5'd31, 16'h0000, 5'd7, 16'h0038, 5, {
			imm_form(pipe16_pkg::op_movl, 8'h25, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h13, 4'd2),
			reg_form(pipe16_pkg::op_add, 4'd1, 4'd2, 4'd3), imm_form(pipe16_pkg::op_movl, 8'h07, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd3)});
		table_entry("sub", 5'd31, 16'h0000, 5'd8, 16'hffe0, 5, {
			imm_form(pipe16_pkg::op_movl, 8'h10, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h30, 4'd2),
			reg_form(pipe16_pkg::op_sub, 4'd1, 4'd2, 4'd3), imm_form(pipe16_pkg::op_movl, 8'h08, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd3)});
		table_entry("inc", 5'd31, 16'h0000, 5'd9, 16'h00a0, 4, {
			imm_form(pipe16_pkg::op_movl, 8'h7f, 4'd1), imm_form(pipe16_pkg::op_inc, 8'h21, 4'd1),
			imm_form(pipe16_pkg::op_movl, 8'h09, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd2, pipe16_pkg::xop_st, 4'd1)});
		table_entry("dec", 5'd31, 16'h0000, 5'd10, 16'hfffe, 4, {
			imm_form(pipe16_pkg::op_movl, 8'h05, 4'd1), imm_form(pipe16_pkg::op_dec, 8'h07, 4'd1),
			imm_form(pipe16_pkg::op_movl, 8'h0a, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd2, pipe16_pkg::xop_st, 4'd1)});
		table_entry("cmp_equal", 5'd31, 16'h0000, 5'd11, 16'h0001, 5, {
			imm_form(pipe16_pkg::op_movl, 8'h42, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h42, 4'd2),
			reg_form(pipe16_pkg::op_cmp, 4'd1, 4'd2, 4'd3), imm_form(pipe16_pkg::op_movl, 8'h0b, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd3)});
		table_entry("cmp_differ", 5'd31, 16'h0000, 5'd12, 16'h0000, 5, {
			imm_form(pipe16_pkg::op_movl, 8'h42, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h43, 4'd2),
			reg_form(pipe16_pkg::op_cmp, 4'd1, 4'd2, 4'd3), imm_form(pipe16_pkg::op_movl, 8'h0c, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd3)});
		// Each add needs the result of the one right before it
		table_entry("forward_chain", 5'd31, 16'h0000, 5'd13, 16'h000c, 7, {
			imm_form(pipe16_pkg::op_movl, 8'h03, 4'd1), reg_form(pipe16_pkg::op_add, 4'd1, 4'd1, 4'd2),
			reg_form(pipe16_pkg::op_add, 4'd2, 4'd1, 4'd3), reg_form(pipe16_pkg::op_add, 4'd3, 4'd2, 4'd4),
			reg_form(pipe16_pkg::op_sub, 4'd4, 4'd1, 4'd5), imm_form(pipe16_pkg::op_movl, 8'h0d, 4'd6),
			reg_form(pipe16_pkg::op_mem, 4'd6, pipe16_pkg::xop_st, 4'd5)});
		table_entry("load_use", 5'd20, 16'h1111, 5'd21, 16'h2222, 5, {
			imm_form(pipe16_pkg::op_movl, 8'h14, 4'd1),
			reg_form(pipe16_pkg::op_mem, 4'd1, pipe16_pkg::xop_ld, 4'd2),
			reg_form(pipe16_pkg::op_add, 4'd2, 4'd2, 4'd3), imm_form(pipe16_pkg::op_movl, 8'h15, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd3)});
		table_entry("load_store", 5'd22, 16'hbeef, 5'd23, 16'hbeef, 4, {
			imm_form(pipe16_pkg::op_movl, 8'h16, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h17, 4'd3),
			reg_form(pipe16_pkg::op_mem, 4'd1, pipe16_pkg::xop_ld, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd3, pipe16_pkg::xop_st, 4'd2)});
		// Five passes through the body at pc 6, counted up in r2
		table_entry("loop_jnz", 5'd31, 16'h0000, 5'd24, 16'h0005, 9, {
			imm_form(pipe16_pkg::op_movl, 8'h05, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h00, 4'd2),
			imm_form(pipe16_pkg::op_movl, 8'h06, 4'd3), imm_form(pipe16_pkg::op_inc, 8'h01, 4'd2),
			imm_form(pipe16_pkg::op_dec, 8'h01, 4'd1),
			reg_form(pipe16_pkg::op_jump, 4'd1, pipe16_pkg::xop_jnz, 4'd3),
			imm_form(pipe16_pkg::op_movl, 8'h18, 4'd4),
			reg_form(pipe16_pkg::op_mem, 4'd4, pipe16_pkg::xop_st, 4'd2), illegal_word});
		branch_case("jz_taken", pipe16_pkg::xop_jz, 8'h00, 1'b1, 5'd14);
		branch_case("jz_not_taken", pipe16_pkg::xop_jz, 8'h03, 1'b0, 5'd15);
		branch_case("jnz_not_taken", pipe16_pkg::xop_jnz, 8'h00, 1'b0, 5'd16);
		branch_case("js_taken", pipe16_pkg::xop_js, 8'h80, 1'b1, 5'd17);
		branch_case("js_not_taken", pipe16_pkg::xop_js, 8'h05, 1'b0, 5'd18);
		branch_case("jns_taken", pipe16_pkg::xop_jns, 8'h05, 1'b1, 5'd19);
		branch_case("jns_not_taken", pipe16_pkg::xop_jns, 8'h80, 1'b0, 5'd25);
		table_entry("r0_write", 5'd31, 16'h0000, 5'd27, 16'h0000, 4, {
			imm_form(pipe16_pkg::op_movl, 8'h77, 4'd0), reg_form(pipe16_pkg::op_add, 4'd0, 4'd0, 4'd1),
			imm_form(pipe16_pkg::op_movl, 8'h1b, 4'd2),
			reg_form(pipe16_pkg::op_mem, 4'd2, pipe16_pkg::xop_st, 4'd1)});
		// The store right behind the illegal word must never reach memory
		table_entry("illegal_halt", 5'd31, 16'h0000, 5'd26, 16'h005a, 6, {
			imm_form(pipe16_pkg::op_movl, 8'h1a, 4'd1), imm_form(pipe16_pkg::op_movl, 8'h5a, 4'd2),
			imm_form(pipe16_pkg::op_movl, 8'h33, 4'd3),
			reg_form(pipe16_pkg::op_mem, 4'd1, pipe16_pkg::xop_st, 4'd2), illegal_word,
			reg_form(pipe16_pkg::op_mem, 4'd1, pipe16_pkg::xop_st, 4'd3)});
	endtask

	initial begin
		int errors_before;
		int cycles;
		void'($urandom(29828));
		rst = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_instr = '0;
		load_data = '0;
		peek_addr = '0;
		num_tests = 0;
		error_count = 0;
		pass_count = 0;
		build_table();
		@(posedge clk);
		#1;
		for (int n = 0; n < num_tests; n++) begin
			errors_before = error_count;
			fill_memories(n);
			apply_reset();
			peek_addr = check_addr[n];
			cycles = 0;
			while (halt !== 1'b1 && cycles < run_limit) begin
				@(posedge clk);
				#1;
				cycles++;
			end
			compare_bit({names[n], " halt"}, 1'b1, halt);
			compare_word(names[n], expected[n], peek_data);
			if (error_count == errors_before) begin
				pass_count++;
				$display("test %0s finished correctly after %0d cycles", names[n], cycles);
			end else begin
				$display("test %0s finished with errors", names[n]);
			end
		end
		$display("%0d tests run, %0d passed, %0d failed", num_tests, pass_count,
			num_tests - pass_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Each test needs a memory load, a reset and at most run_limit cycles, well under 200
	initial begin
		@(posedge clk);
		repeat (num_tests * 200) @(posedge clk);
		$display("Watchdog expired, the tests did not finish within %0d cycles", num_tests * 200);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== verif/pipe16_tb_mem.sv ====
`timescale 1ns/10ps

module pipe16_tb_mem (
	input logic clk,
	input pipe16_pkg::word_t imem_addr,
	output pipe16_pkg::word_t imem_data,
	input pipe16_pkg::word_t dmem_raddr,
	output pipe16_pkg::word_t dmem_rdata,
	input logic dmem_wen,
	input pipe16_pkg::word_t dmem_waddr,
	input pipe16_pkg::word_t dmem_wdata,
	input logic load_en,
	input logic [4:0] load_addr,
	input pipe16_pkg::word_t load_instr,
	input pipe16_pkg::word_t load_data,
	input logic [4:0] peek_addr,
	output pipe16_pkg::word_t peek_data
);

	// Sixteen instruction words at byte addresses, thirty-two data words at word addresses
	pipe16_pkg::word_t imem [16];
	pipe16_pkg::word_t dmem [32];

	assign peek_data = dmem[peek_addr];

	always_ff @(posedge clk) begin
		imem_data <= imem[imem_addr[4:1]];
		dmem_rdata <= dmem[dmem_raddr[4:0]];
	end

	// The loader owns the data memory while it runs, the core writes it otherwise
	always_ff @(posedge clk) begin
		if (load_en) begin
			if (!load_addr[4]) begin
				imem[load_addr[3:0]] <= load_instr;
			end
			dmem[load_addr] <= load_data;
		end else if (dmem_wen) begin
			dmem[dmem_waddr[4:0]] <= dmem_wdata;
		end
	end

endmodule
